// File: p4_router_egress.f
+incdir+hdl
hdl/egress_pkg.sv
hdl/egress_demux.sv
hdl/egress_width_adapt.sv
hdl/egress_packet_buffer.sv
hdl/egress_port_array.sv
hdl/p4_router_egress.sv
tests/egress_clk_gen.sv
tests/egress_chk.sv
tests/p4_router_egress_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the egress testbench with Verilator; exit status follows the result
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f p4_router_egress.f \
    --top-module p4_router_egress_tb -o sim_egress && \
./obj_dir/sim_egress | grep -x "test passed" && \
echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/p4_router_egress_tb.sv
/* Table-driven testbench for the egress subsystem. Output beats are checked at the
   falling edge, where DUT outputs and readies are stable until the next rising edge. */

`timescale 1ns/10ps
`default_nettype none

`include "egress_settings.svh"

module p4_router_egress_tb;

    import egress_pkg::*;

    localparam int RDY_FULL  = 0;
    localparam int RDY_RAND  = 1;
    localparam int RDY_HOLD  = 2;
    localparam int LIMIT     = 2000;
    localparam int NUM_TESTS = 22;
    // Admission model of an 8-byte port
    localparam int MTU_8B    = `EGR_MTU_BYTES / `EGR_BUS_BYTES;

    typedef struct {
        string name;
        int    dest;
        int    len;
        int    stall;
    } pkt_entry_t;

    pkt_entry_t tests [NUM_TESTS] = '{
        '{"route_p0", 0, 24, RDY_FULL},      '{"route_p1", 1, 32, RDY_FULL},
        '{"route_p2", 2, 16, RDY_FULL},      '{"route_p3", 3, 8, RDY_FULL},
        '{"narrow_len1", 2, 1, RDY_FULL},    '{"narrow_len3", 3, 3, RDY_FULL},
        '{"narrow_len13", 2, 13, RDY_FULL},  '{"narrow_len32", 3, 32, RDY_FULL},
        '{"bp_p0", 0, 29, RDY_RAND},         '{"bp_p2", 2, 31, RDY_RAND},
        '{"bp_p1", 1, 17, RDY_RAND},         '{"bp_p3", 3, 7, RDY_RAND},
        '{"bp_p2_again", 2, 20, RDY_RAND},   '{"bp_p0_again", 0, 9, RDY_RAND},
        '{"cong_a", 0, 32, RDY_HOLD},        '{"cong_b", 0, 32, RDY_HOLD},
        '{"cong_c", 0, 32, RDY_HOLD},        '{"cong_d", 0, 8, RDY_HOLD},
        '{"cong_release", 0, 16, RDY_FULL},  '{"bad_idx4", 4, 16, RDY_FULL},
        '{"bad_idx7", 7, 8, RDY_FULL},       '{"after_bad", 2, 10, RDY_FULL}
    };

    logic                                          clk;
    logic                                          reset;
    egr_ingress_beat_t                             ingress_beat;
    logic                                          ingress_valid;
    logic                                          ingress_ready;
    egr_wide_beat_t   [`EGR_NUM_8B_PORTS-1:0]      port_8b_beat;
    logic [`EGR_NUM_8B_PORTS-1:0]                  port_8b_valid;
    logic [`EGR_NUM_8B_PORTS-1:0]                  port_8b_ready;
    logic [`EGR_NUM_8B_PORTS-1:0]                  port_8b_overflow;
    egr_narrow_beat_t [`EGR_NUM_2B_PORTS-1:0]      port_2b_beat;
    logic [`EGR_NUM_2B_PORTS-1:0]                  port_2b_valid;
    logic [`EGR_NUM_2B_PORTS-1:0]                  port_2b_ready;
    logic [`EGR_NUM_2B_PORTS-1:0]                  port_2b_overflow;

    egr_wide_beat_t   exp_8b [`EGR_NUM_8B_PORTS][$];
    egr_narrow_beat_t exp_2b [`EGR_NUM_2B_PORTS][$];
    int               exp_ovf [`EGR_NUM_PORTS];
    int               ovf_seen [`EGR_NUM_PORTS];
    int               rdy_mode;
    int               hold_port;
    int               occ_8b;
    int               error_count;
    string            cur_test;

    egress_clk_gen #(.PERIOD_NS(100)) clk_gen0 (.clk(clk));

    p4_router_egress dut0 (.*);

    ////////////////////////////////////////////////////////////
    // Reporting

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s (test %s)", msg, cur_test);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            $display("test failed");
            $fatal(1, "simulation stopped");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Ready gating and output scoreboard

    always @(negedge clk) begin
        logic [`EGR_NUM_PORTS-1:0] rdy;
        egr_wide_beat_t            wb;
        egr_narrow_beat_t          nb;
        // New readies first, so the checks below see what the next edge sees
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            case (rdy_mode)
                RDY_RAND: rdy[p] = ($urandom % 4) != 0;
                RDY_HOLD: rdy[p] = (p != hold_port);
                default:  rdy[p] = 1'b1;
            endcase
        end
        port_8b_ready = rdy[`EGR_NUM_8B_PORTS-1:0];
        port_2b_ready = rdy[`EGR_NUM_PORTS-1:`EGR_NUM_8B_PORTS];
        if (!reset) begin
            for (int p = 0; p < `EGR_NUM_8B_PORTS; p++) begin
                if (port_8b_valid[p] && port_8b_ready[p]) begin
                    if (exp_8b[p].size() == 0) begin
                        fail_run($sformatf("Beat on 8-byte port %0d with none expected", p));
                    end else begin
                        wb = exp_8b[p].pop_front();
                        check_value($sformatf("port %0d beat", p), 128'(wb),
                                    128'(port_8b_beat[p]));
                    end
                end
                if (port_8b_overflow[p]) begin
                    ovf_seen[p]++;
                end
            end
            for (int p = 0; p < `EGR_NUM_2B_PORTS; p++) begin
                if (port_2b_valid[p] && port_2b_ready[p]) begin
                    if (exp_2b[p].size() == 0) begin
                        fail_run($sformatf("Beat on 2-byte port %0d with none expected", p));
                    end else begin
                        nb = exp_2b[p].pop_front();
                        check_value($sformatf("port %0d beat", p + 2), 128'(nb),
                                    128'(port_2b_beat[p]));
                    end
                end
                if (port_2b_overflow[p]) begin
                    ovf_seen[p + 2]++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    // Builds one packet, queues its expected beats and drives it beat by beat
    task automatic send_packet(input int dest, input int len);
        logic [7:0]       bytes [$];
        egr_wide_beat_t   wb;
        egr_narrow_beat_t nb;
        logic             admit;
        int               nbeats;
        int               n;
        int               tries;
        nbeats = (len + 7) / 8;
        for (int b = 0; b < len; b++) begin
            bytes.push_back(8'($urandom));
        end
        // Only a held port can fill up and drop
        admit = 1'b1;
        if (rdy_mode == RDY_HOLD && dest == hold_port && dest < `EGR_NUM_8B_PORTS) begin
            if (occ_8b <= `EGR_BUF_DEPTH_8B - MTU_8B) begin
                occ_8b += nbeats;
            end else begin
                admit = 1'b0;
                exp_ovf[dest]++;
            end
        end
        for (int b = 0; b < nbeats; b++) begin
            wb = '0;
            n = len - 8 * b;
            if (n > 8) begin
                n = 8;
            end
            for (int k = 0; k < n; k++) begin
                wb.data[8*k +: 8] = bytes[8*b + k];
                wb.keep[k] = 1'b1;
            end
            wb.last = (b == nbeats - 1);
            if (dest < `EGR_NUM_8B_PORTS && admit) begin
                exp_8b[dest].push_back(wb);
            end else if (dest >= `EGR_NUM_8B_PORTS && dest < `EGR_NUM_PORTS) begin
                for (int s = 0; 2 * s < n; s++) begin
                    nb.data = wb.data[16*s +: 16];
                    nb.keep = wb.keep[2*s +: 2];
                    nb.last = wb.last && (2 * s + 2 >= n);
                    exp_2b[dest - `EGR_NUM_8B_PORTS].push_back(nb);
                end
            end
            ingress_beat.beat = wb;
            ingress_beat.user = 3'(dest);
            ingress_valid = 1'b1;
            tries = 0;
            while (!ingress_ready) begin
                tries++;
                if (tries > LIMIT) begin
                    fail_run("Timeout: ingress_ready stayed low");
                end
                @(negedge clk);
            end
            @(negedge clk);
        end
        ingress_valid = 1'b0;
    endtask

    // Releases all ports and waits until every expected beat has come out
    task automatic drain_ports();
        int tries;
        int pending;
        rdy_mode = RDY_FULL;
        tries = 0;
        pending = 1;
        while (pending != 0) begin
            pending = 0;
            for (int p = 0; p < `EGR_NUM_8B_PORTS; p++) begin
                pending += exp_8b[p].size();
            end
            for (int p = 0; p < `EGR_NUM_2B_PORTS; p++) begin
                pending += exp_2b[p].size();
            end
            tries++;
            if (tries > LIMIT) begin
                fail_run("Timeout: expected beats never arrived");
            end
            @(negedge clk);
        end
        occ_8b = 0;
    endtask

    initial begin
        void'($urandom(32'h93c3125d));
        error_count   = 0;
        rdy_mode      = RDY_FULL;
        hold_port     = 0;
        occ_8b        = 0;
        cur_test      = "reset_state";
        reset         = 1'b1;
        ingress_valid = 1'b0;
        ingress_beat  = '0;
        port_8b_ready = '1;
        port_2b_ready = '1;
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            exp_ovf[p]  = 0;
            ovf_seen[p] = 0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("8-byte valids", 128'(0), 128'(port_8b_valid));
        check_value("2-byte valids", 128'(0), 128'(port_2b_valid));
        check_value("overflow flags", 128'(0), 128'({port_2b_overflow, port_8b_overflow}));
        check_value("ingress_ready", 128'(1), 128'(ingress_ready));

        for (int i = 0; i < NUM_TESTS; i++) begin
            cur_test = tests[i].name;
            if (rdy_mode != tests[i].stall) begin
                rdy_mode  = tests[i].stall;
                hold_port = tests[i].dest;
                @(negedge clk);
            end
            send_packet(tests[i].dest, tests[i].len);
            if (i == NUM_TESTS - 1 || tests[i + 1].stall != tests[i].stall) begin
                drain_ports();
            end
        end

        cur_test = "overflow_count";
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            check_value($sformatf("port %0d overflow pulses", p), 128'(exp_ovf[p]),
                        128'(ovf_seen[p]));
        end

        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/egress_chk.sv
/* Protocol assertions on the egress top level. Checked only outside reset. */

`timescale 1ns/10ps
`default_nettype none

`include "egress_settings.svh"

module egress_chk (
    input logic                                                 clk,
    input logic                                                 reset,
    input logic [`EGR_NUM_PORTS-1:0]                            demux_valid,
    input egress_pkg::egr_wide_beat_t   [`EGR_NUM_8B_PORTS-1:0] port_8b_beat,
    input logic [`EGR_NUM_8B_PORTS-1:0]                         port_8b_valid,
    input logic [`EGR_NUM_8B_PORTS-1:0]                         port_8b_ready,
    input egress_pkg::egr_narrow_beat_t [`EGR_NUM_2B_PORTS-1:0] port_2b_beat,
    input logic [`EGR_NUM_2B_PORTS-1:0]                         port_2b_valid,
    input logic [`EGR_NUM_2B_PORTS-1:0]                         port_2b_ready
);

    import egress_pkg::*;

    // Shared demux register feeds at most one port
    a_demux_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(demux_valid))
        else $error("demux valid is not one-hot");

    for (genvar i = 0; i < `EGR_NUM_8B_PORTS; i++) begin : g_wide
        a_hold: assert property (@(posedge clk) disable iff (reset)
            port_8b_valid[i] && !port_8b_ready[i]
            |=> port_8b_valid[i] && $stable(port_8b_beat[i]))
            else $error("8-byte port %0d dropped valid or changed beat", i);
        a_keep: assert property (@(posedge clk) disable iff (reset)
            port_8b_valid[i] |-> (port_8b_beat[i].keep != 8'd0) &&
            ((port_8b_beat[i].keep & (port_8b_beat[i].keep + 8'd1)) == 8'd0))
            else $error("8-byte port %0d keep not contiguous", i);
    end

    for (genvar i = 0; i < `EGR_NUM_2B_PORTS; i++) begin : g_narrow
        a_hold: assert property (@(posedge clk) disable iff (reset)
            port_2b_valid[i] && !port_2b_ready[i]
            |=> port_2b_valid[i] && $stable(port_2b_beat[i]))
            else $error("2-byte port %0d dropped valid or changed beat", i);
        a_keep: assert property (@(posedge clk) disable iff (reset)
            port_2b_valid[i] |-> (port_2b_beat[i].keep == 2'b01) ||
            (port_2b_beat[i].keep == 2'b11))
            else $error("2-byte port %0d keep not contiguous", i);
    end

endmodule

bind p4_router_egress egress_chk chk0 (
    .clk           ( clk           ),
    .reset         ( reset         ),
    .demux_valid   ( demux_valid   ),
    .port_8b_beat  ( port_8b_beat  ),
    .port_8b_valid ( port_8b_valid ),
    .port_8b_ready ( port_8b_ready ),
    .port_2b_beat  ( port_2b_beat  ),
    .port_2b_valid ( port_2b_valid ),
    .port_2b_ready ( port_2b_ready )
);

`default_nettype wire

// File: tests/egress_clk_gen.sv
/* Free-running testbench clock, starting low; PERIOD_NS should be even. */

`timescale 1ns/10ps
`default_nettype none

module egress_clk_gen #(
    parameter int PERIOD_NS = 100
)(
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: hdl/p4_router_egress.sv
/* Egress subsystem on a single clock. Index 0..1 selects an 8-byte port, 2..3 a
   2-byte port, 4..7 drops the packet; overflow pulses mark congestion drops. */

`timescale 1ns/10ps
`default_nettype none

`include "egress_settings.svh"

module p4_router_egress (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  egress_pkg::egr_ingress_beat_t                           ingress_beat,
    input  logic                                                    ingress_valid,
    output logic                                                    ingress_ready,
    output egress_pkg::egr_wide_beat_t   [`EGR_NUM_8B_PORTS-1:0]    port_8b_beat,
    output logic [`EGR_NUM_8B_PORTS-1:0]                            port_8b_valid,
    input  logic [`EGR_NUM_8B_PORTS-1:0]                            port_8b_ready,
    output logic [`EGR_NUM_8B_PORTS-1:0]                            port_8b_overflow,
    output egress_pkg::egr_narrow_beat_t [`EGR_NUM_2B_PORTS-1:0]    port_2b_beat,
    output logic [`EGR_NUM_2B_PORTS-1:0]                            port_2b_valid,
    input  logic [`EGR_NUM_2B_PORTS-1:0]                            port_2b_ready,
    output logic [`EGR_NUM_2B_PORTS-1:0]                            port_2b_overflow
);

    import egress_pkg::*;

    egr_wide_beat_t                                           demux_beat;
    logic [`EGR_NUM_PORTS-1:0]                                demux_valid;
    logic [`EGR_NUM_8B_PORTS-1:0]                             ready_8b;
    logic [`EGR_NUM_2B_PORTS-1:0]                             ready_2b;
    logic [`EGR_NUM_8B_PORTS-1:0][`EGR_BUS_BYTES*8-1:0]       data_8b;
    logic [`EGR_NUM_8B_PORTS-1:0][`EGR_BUS_BYTES-1:0]         keep_8b;
    logic [`EGR_NUM_8B_PORTS-1:0]                             last_8b;
    logic [`EGR_NUM_2B_PORTS-1:0][EGR_NARROW_BYTES*8-1:0]     data_2b;
    logic [`EGR_NUM_2B_PORTS-1:0][EGR_NARROW_BYTES-1:0]       keep_2b;
    logic [`EGR_NUM_2B_PORTS-1:0]                             last_2b;

    ////////////////////////////////////////////////////////////
    // Demux, low indexes feed the 8-byte class

    egress_demux demux0 (
        .clk       ( clk                   ),
        .reset     ( reset                 ),
        .in_beat   ( ingress_beat          ),
        .in_valid  ( ingress_valid         ),
        .in_ready  ( ingress_ready         ),
        .out_beat  ( demux_beat            ),
        .out_valid ( demux_valid           ),
        .out_ready ( {ready_2b, ready_8b}  )
    );

    ////////////////////////////////////////////////////////////
    // Port classes

    egress_port_array #(
        .NUM_PORTS  ( `EGR_NUM_8B_PORTS ),
        .PORT_BYTES ( `EGR_BUS_BYTES    )
    ) array_8b (
        .clk       ( clk                                      ),
        .reset     ( reset                                    ),
        .in_beat   ( {`EGR_NUM_8B_PORTS{demux_beat}}          ),
        .in_valid  ( demux_valid[`EGR_NUM_8B_PORTS-1:0]       ),
        .in_ready  ( ready_8b                                 ),
        .out_data  ( data_8b                                  ),
        .out_keep  ( keep_8b                                  ),
        .out_last  ( last_8b                                  ),
        .out_valid ( port_8b_valid                            ),
        .out_ready ( port_8b_ready                            ),
        .overflow  ( port_8b_overflow                         )
    );

    egress_port_array #(
        .NUM_PORTS  ( `EGR_NUM_2B_PORTS ),
        .PORT_BYTES ( EGR_NARROW_BYTES  )
    ) array_2b (
        .clk       ( clk                                                  ),
        .reset     ( reset                                                ),
        .in_beat   ( {`EGR_NUM_2B_PORTS{demux_beat}}                      ),
        .in_valid  ( demux_valid[`EGR_NUM_PORTS-1:`EGR_NUM_8B_PORTS]      ),
        .in_ready  ( ready_2b                                             ),
        .out_data  ( data_2b                                              ),
        .out_keep  ( keep_2b                                              ),
        .out_last  ( last_2b                                              ),
        .out_valid ( port_2b_valid                                        ),
        .out_ready ( port_2b_ready                                        ),
        .overflow  ( port_2b_overflow                                     )
    );

    // Regroup the array outputs into beat structs
    for (genvar i = 0; i < `EGR_NUM_8B_PORTS; i++) begin : g_pack_8b
        assign port_8b_beat[i] = '{data: data_8b[i], keep: keep_8b[i], last: last_8b[i]};
    end

    for (genvar i = 0; i < `EGR_NUM_2B_PORTS; i++) begin : g_pack_2b
        assign port_2b_beat[i] = '{data: data_2b[i], keep: keep_2b[i], last: last_2b[i]};
    end

endmodule

`default_nettype wire

// File: hdl/egress_port_array.sv
/* One width class of egress ports. PORT_BYTES must be 2 or 8; 2-byte ports
   get a width adapter ahead of their buffer and are the only ones that stall. */

`timescale 1ns/10ps
`default_nettype none

`include "egress_settings.svh"

module egress_port_array #(
    parameter int NUM_PORTS  = 2,
    parameter int PORT_BYTES = 8
)(
    input  logic                                      clk,
    input  logic                                      reset,
    input  egress_pkg::egr_wide_beat_t [NUM_PORTS-1:0] in_beat,
    input  logic [NUM_PORTS-1:0]                      in_valid,
    output logic [NUM_PORTS-1:0]                      in_ready,
    output logic [NUM_PORTS-1:0][PORT_BYTES*8-1:0]    out_data,
    output logic [NUM_PORTS-1:0][PORT_BYTES-1:0]      out_keep,
    output logic [NUM_PORTS-1:0]                      out_last,
    output logic [NUM_PORTS-1:0]                      out_valid,
    input  logic [NUM_PORTS-1:0]                      out_ready,
    output logic [NUM_PORTS-1:0]                      overflow
);

    import egress_pkg::*;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        if (PORT_BYTES == EGR_NARROW_BYTES) begin : g_narrow
            egr_narrow_beat_t adapt_beat;
            logic             adapt_valid;
            egr_narrow_beat_t buf_beat;

            // Buffer never stalls, so the adapter runs at full rate
            egress_width_adapt adapt0 (
                .clk       ( clk         ),
                .reset     ( reset       ),
                .in_beat   ( in_beat[i]  ),
                .in_valid  ( in_valid[i] ),
                .in_ready  ( in_ready[i] ),
                .out_beat  ( adapt_beat  ),
                .out_valid ( adapt_valid ),
                .out_ready ( 1'b1        )
            );

            egress_packet_buffer #(
                .beat_t    ( egr_narrow_beat_t                      ),
                .DEPTH     ( `EGR_BUF_DEPTH_2B                      ),
                .MTU_BEATS ( `EGR_MTU_BYTES / EGR_NARROW_BYTES      )
            ) buf0 (
                .clk       ( clk          ),
                .reset     ( reset        ),
                .in_beat   ( adapt_beat   ),
                .in_valid  ( adapt_valid  ),
                .out_beat  ( buf_beat     ),
                .out_valid ( out_valid[i] ),
                .out_ready ( out_ready[i] ),
                .overflow  ( overflow[i]  )
            );

            assign out_data[i] = buf_beat.data;
            assign out_keep[i] = buf_beat.keep;
            assign out_last[i] = buf_beat.last;
        end else begin : g_wide
            egr_wide_beat_t buf_beat;

            assign in_ready[i] = 1'b1;

            egress_packet_buffer #(
                .beat_t    ( egr_wide_beat_t                        ),
                .DEPTH     ( `EGR_BUF_DEPTH_8B                      ),
                .MTU_BEATS ( `EGR_MTU_BYTES / `EGR_BUS_BYTES        )
            ) buf0 (
                .clk       ( clk          ),
                .reset     ( reset        ),
                .in_beat   ( in_beat[i]   ),
                .in_valid  ( in_valid[i]  ),
                .out_beat  ( buf_beat     ),
                .out_valid ( out_valid[i] ),
                .out_ready ( out_ready[i] ),
                .overflow  ( overflow[i]  )
            );

            assign out_data[i] = buf_beat.data;
            assign out_keep[i] = buf_beat.keep;
            assign out_last[i] = buf_beat.last;
        end
    end

endmodule

`default_nettype wire

// File: hdl/egress_packet_buffer.sv
/* Synchronous packet FIFO that never stalls its input. A packet is admitted only if
   MTU_BEATS words are free at its first beat; otherwise all of it is dropped. */

`timescale 1ns/10ps
`default_nettype none

module egress_packet_buffer #(
    parameter type beat_t    = egress_pkg::egr_wide_beat_t,
    parameter int  DEPTH     = 8,
    parameter int  MTU_BEATS = 4
)(
    input  logic  clk,
    input  logic  reset,
    input  beat_t in_beat,
    input  logic  in_valid,
    output beat_t out_beat,
    output logic  out_valid,
    input  logic  out_ready,
    output logic  overflow
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    beat_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             in_pkt;
    logic             drop_r;
    logic             first;
    logic             admit;
    logic             discard;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (int'(ptr) == DEPTH - 1) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    ////////////////////////////////////////////////////////////
    // Admission

    assign first   = ~in_pkt;
    assign admit   = int'(count) <= DEPTH - MTU_BEATS;
    assign discard = first ? ~admit : drop_r;

    // Full check only matters for packets longer than the MTU
    assign wr_en = in_valid & ~discard & (int'(count) != DEPTH);

    // Congestion drop, flagged on the first beat only
    assign overflow = in_valid & first & ~admit;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt <= 1'b0;
            drop_r <= 1'b0;
        end else if (in_valid) begin
            in_pkt <= ~in_beat.last;
            if (first) begin
                drop_r <= ~admit;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage

    assign out_valid = count != '0;
    assign out_beat  = mem[rd_ptr];
    assign rd_en     = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: hdl/egress_width_adapt.sv
/* Splits each wide beat into 2-byte beats from byte 0 up, one per cycle. Expects
   contiguous keep with at least one byte set; a partial beat is only legal with last. */

`timescale 1ns/10ps
`default_nettype none

`include "egress_settings.svh"

module egress_width_adapt (
    input  logic                         clk,
    input  logic                         reset,
    input  egress_pkg::egr_wide_beat_t   in_beat,
    input  logic                         in_valid,
    output logic                         in_ready,
    output egress_pkg::egr_narrow_beat_t out_beat,
    output logic                         out_valid,
    input  logic                         out_ready
);

    import egress_pkg::*;

    localparam int SLICES = `EGR_BUS_BYTES / EGR_NARROW_BYTES;
    localparam int IDX_W  = $clog2(SLICES);

    egr_wide_beat_t            hold;
    logic                      full;
    logic [IDX_W-1:0]          idx;
    logic [`EGR_BUS_BYTES-1:0] keep_rest;
    logic                      final_slice;
    logic                      load;
    logic                      fire;

    ////////////////////////////////////////////////////////////
    // Slice select

    // Keep bits above the current slice; none left means this slice ends the beat
    assign keep_rest   = hold.keep >> (EGR_NARROW_BYTES * (int'(idx) + 1));
    assign final_slice = ~keep_rest[0];

    always_comb begin
        out_beat.data = hold.data[EGR_NARROW_BYTES*8*idx +: EGR_NARROW_BYTES*8];
        out_beat.keep = hold.keep[EGR_NARROW_BYTES*idx +: EGR_NARROW_BYTES];
        out_beat.last = hold.last & final_slice;
    end

    assign out_valid = full;
    assign fire      = full & out_ready;

    // Next wide beat may load on the cycle the final slice leaves
    assign in_ready = ~full | (out_ready & final_slice);
    assign load     = in_valid & in_ready;

    ////////////////////////////////////////////////////////////
    // State

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
            idx  <= '0;
        end else if (load) begin
            full <= 1'b1;
            idx  <= '0;
        end else if (fire) begin
            if (final_slice) begin
                full <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold <= in_beat;
        end
    end

endmodule

`default_nettype wire

// File: hdl/egress_demux.sv
/* Routes whole packets by the user field of their first beat; indexes without a port
   are accepted and discarded. One output register serves every port. */

`timescale 1ns/10ps
`default_nettype none

`include "egress_settings.svh"

module egress_demux (
    input  logic                          clk,
    input  logic                          reset,
    input  egress_pkg::egr_ingress_beat_t in_beat,
    input  logic                          in_valid,
    output logic                          in_ready,
    output egress_pkg::egr_wide_beat_t    out_beat,
    output logic [`EGR_NUM_PORTS-1:0]     out_valid,
    input  logic [`EGR_NUM_PORTS-1:0]     out_ready
);

    import egress_pkg::*;

    logic                      in_pkt;
    logic [2:0]                dest_r;
    logic [2:0]                dest;
    egr_port_idx_t             port;
    logic [`EGR_NUM_PORTS-1:0] port_onehot;
    logic                      drain;
    logic                      accept;

    ////////////////////////////////////////////////////////////
    // Destination select

    // First beat takes the index from the bus, later beats from the latch
    assign dest = in_pkt ? dest_r : in_beat.user;
    assign port = egr_port_idx_t'(dest);

    always_comb begin
        port_onehot = '0;
        port_onehot[port] = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Handshake

    assign drain    = |(out_valid & out_ready);
    assign in_ready = ~(|out_valid) | drain;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt    <= 1'b0;
            dest_r    <= '0;
            out_valid <= '0;
        end else if (accept) begin
            in_pkt <= ~in_beat.beat.last;
            dest_r <= dest;
            // Beat of an unknown destination is taken but never presented
            if (int'(dest) < `EGR_NUM_PORTS) begin
                out_valid <= port_onehot;
            end else begin
                out_valid <= '0;
            end
        end else if (drain) begin
            out_valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_beat <= in_beat.beat;
        end
    end

endmodule

`default_nettype wire

// File: hdl/egress_pkg.sv
/* Stream beat types of the egress path. Keep bits are contiguous from byte 0
   and only the last beat of a packet may be partial. */

`default_nettype none

`include "egress_settings.svh"

package egress_pkg;

    // Width of the narrow physical ports
    localparam int EGR_NARROW_BYTES = 2;

    // Ports 0..1 are 8-byte ports, 2..3 are 2-byte ports
    typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] egr_port_idx_t;

    ////////////////////////////////////////////////////////////
    // Beat types

    typedef struct packed {
        logic [`EGR_BUS_BYTES*8-1:0] data;
        logic [`EGR_BUS_BYTES-1:0]   keep;
        logic                        last;
    } egr_wide_beat_t;

    // Three user bits so that indexes with no port behind them can be sent
    typedef struct packed {
        egr_wide_beat_t beat;
        logic [2:0]     user;
    } egr_ingress_beat_t;

    typedef struct packed {
        logic [EGR_NARROW_BYTES*8-1:0] data;
        logic [EGR_NARROW_BYTES-1:0]   keep;
        logic                          last;
    } egr_narrow_beat_t;

endpackage

`default_nettype wire

// File: hdl/egress_settings.svh
/* Sizes of the egress subsystem. Buffer depths must be powers of two and at least
   the MTU in beats of their port class, or a lone maximum packet is always dropped. */

`ifndef EGRESS_SETTINGS_SVH
`define EGRESS_SETTINGS_SVH

// Wide ingress bus
`define EGR_BUS_BYTES 8

// Physical egress ports per width class
`define EGR_NUM_8B_PORTS 2
`define EGR_NUM_2B_PORTS 2
`define EGR_NUM_PORTS (`EGR_NUM_8B_PORTS + `EGR_NUM_2B_PORTS)

// Largest packet accepted by the router
`define EGR_MTU_BYTES 32

// Per-port buffer depths, in beats of the port width
`define EGR_BUF_DEPTH_8B 8
`define EGR_BUF_DEPTH_2B 32

`endif
